/* source/pe_pkg.sv */
package pe_pkg;

	// stream word and lane widths
	localparam int DATA_W = 32;
	localparam int LANE_W = 8;
	localparam int LANES = 4;

	// lane count 1..4 needs three bits
	localparam int LANE_CNT_W = 3;

	// scratchpad depths
	// filter holds p x rs x q values, 4 x 4 x 4 at most
	localparam int FILTER_LEN = 64;
	localparam int IFMAP_LEN = 16;
	localparam int PSUM_LEN = 4;

	// scratchpad index widths
	localparam int FILTER_IDX_W = 6;
	localparam int IFMAP_IDX_W = 4;
	localparam int PSUM_IDX_W = 2;

	// run configuration, sampled on i_pe_en
	typedef struct packed {
		// filter taps minus one
		logic [1:0] rs_m1;
		// output channels minus one
		logic [1:0] p_m1;
		// index of the last output column
		logic [4:0] f;
		// input channels minus one
		logic [1:0] q_m1;
	} pe_cfg_t;

	// controller states, in the order a column walks through them
	typedef enum logic [2:0] {
		ST_IDLE = 3'd0,
		ST_READ_FILTER = 3'd1,
		ST_READ_IFMAP = 3'd2,
		ST_READ_IPSUM = 3'd3,
		ST_CONV = 3'd4,
		ST_WRITE_OPSUM = 3'd5
	} pe_state_e;

endpackage

/* source/pe_ctrl_if.sv */
`timescale 1ns/100ps

interface pe_ctrl_if import pe_pkg::*; ();

	// stream write strobes and base indices
	logic filter_we;
	logic ifmap_we;
	logic [LANE_CNT_W-1:0] lanes;
	logic [FILTER_IDX_W-1:0] filter_wr_idx;
	logic [IFMAP_IDX_W-1:0] ifmap_wr_idx;
	logic psum_load;
	logic [PSUM_IDX_W-1:0] psum_wr_idx;

	// accumulation pointers
	logic mac_en;
	logic [FILTER_IDX_W-1:0] filter_rd_idx;
	logic [IFMAP_IDX_W-1:0] ifmap_rd_idx;
	logic [PSUM_IDX_W-1:0] result_idx;

	// window slide and output select
	logic ifmap_slide;
	logic [LANE_CNT_W-1:0] slide_by;
	logic [PSUM_IDX_W-1:0] out_idx;

	modport ctrl (
		output filter_we, ifmap_we, lanes, filter_wr_idx, ifmap_wr_idx,
		output psum_load, psum_wr_idx, mac_en, filter_rd_idx, ifmap_rd_idx,
		output result_idx, ifmap_slide, slide_by, out_idx
	);
	modport filter (input filter_we, lanes, filter_wr_idx, filter_rd_idx);
	modport ifmap (input ifmap_we, lanes, ifmap_wr_idx, ifmap_rd_idx, ifmap_slide, slide_by);
	modport psum (input psum_load, psum_wr_idx, mac_en, result_idx, out_idx);

endinterface

/* source/pe_ctrl.sv */
`timescale 1ns/100ps

module pe_ctrl import pe_pkg::*; (
	input logic clk,
	input logic rst,
	input logic i_pe_en,
	input pe_cfg_t i_cfg,
	input logic i_filter_valid,
	input logic i_ifmap_valid,
	input logic i_ipsum_valid,
	input logic i_opsum_ready,
	output logic o_filter_ready,
	output logic o_ifmap_ready,
	output logic o_ipsum_ready,
	output logic o_opsum_valid,
	output logic o_busy,
	pe_ctrl_if.ctrl ctrl_if
);

	pe_cfg_t cfg_q;
	pe_state_e state;
	pe_state_e state_nxt;
	logic [LANE_CNT_W-1:0] q_cnt;
	logic [LANE_CNT_W-1:0] p_cnt;
	logic [LANE_CNT_W-1:0] rs_cnt;
	logic [4:0] filter_words;
	logic [4:0] win_len;
	logic [3:0] filter_word_q;
	logic [FILTER_IDX_W-1:0] filter_wr_q;
	logic [IFMAP_IDX_W-1:0] ifmap_wr_q;
	logic [PSUM_IDX_W-1:0] psum_wr_q;
	logic [FILTER_IDX_W-1:0] filter_rd_q;
	logic [IFMAP_IDX_W-1:0] ifmap_rd_q;
	logic [PSUM_IDX_W-1:0] result_q;
	logic [PSUM_IDX_W-1:0] out_q;
	logic [4:0] col_q;
	logic filter_acc, ifmap_acc, ipsum_acc, opsum_acc, mac_en;
	logic filter_last, ifmap_last, ipsum_last, conv_wrap, conv_last, out_last;
	logic slide;

	assign q_cnt = {1'b0, cfg_q.q_m1} + 3'd1;
	assign p_cnt = {1'b0, cfg_q.p_m1} + 3'd1;
	assign rs_cnt = {1'b0, cfg_q.rs_m1} + 3'd1;
	// p*rs filter words, q*rs values per window
	assign filter_words = 5'(p_cnt) * 5'(rs_cnt);
	assign win_len = 5'(q_cnt) * 5'(rs_cnt);

	// readies are plain state decodes
	assign o_filter_ready = (state == ST_READ_FILTER);
	assign o_ifmap_ready = (state == ST_READ_IFMAP);
	assign o_ipsum_ready = (state == ST_READ_IPSUM);
	assign o_opsum_valid = (state == ST_WRITE_OPSUM);
	assign o_busy = (state != ST_IDLE);
	assign mac_en = (state == ST_CONV);

	assign filter_acc = o_filter_ready && i_filter_valid;
	assign ifmap_acc = o_ifmap_ready && i_ifmap_valid;
	assign ipsum_acc = o_ipsum_ready && i_ipsum_valid;
	assign opsum_acc = o_opsum_valid && i_opsum_ready;

	assign filter_last = filter_acc && ({1'b0, filter_word_q} == filter_words - 5'd1);
	assign ifmap_last = ifmap_acc && (({1'b0, ifmap_wr_q} + 5'(q_cnt)) == win_len);
	assign ipsum_last = ipsum_acc && (psum_wr_q == cfg_q.p_m1);
	// ifmap pointer wraps once per output channel
	assign conv_wrap = ({1'b0, ifmap_rd_q} == win_len - 5'd1);
	assign conv_last = mac_en && conv_wrap && (result_q == cfg_q.p_m1);
	assign out_last = opsum_acc && (out_q == cfg_q.p_m1);
	assign slide = out_last && (col_q != cfg_q.f);

	always_comb begin
		state_nxt = state;
		case (state)
			ST_IDLE: if (i_pe_en) state_nxt = ST_READ_FILTER;
			ST_READ_FILTER: if (filter_last) state_nxt = ST_READ_IFMAP;
			ST_READ_IFMAP: if (ifmap_last) state_nxt = ST_READ_IPSUM;
			ST_READ_IPSUM: if (ipsum_last) state_nxt = ST_CONV;
			ST_CONV: if (conv_last) state_nxt = ST_WRITE_OPSUM;
			ST_WRITE_OPSUM: if (out_last) state_nxt = slide ? ST_READ_IFMAP : ST_IDLE;
			default: state_nxt = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= ST_IDLE;
			cfg_q <= '0;
		end else begin
			state <= state_nxt;
			if (state == ST_IDLE && i_pe_en)
				cfg_q <= i_cfg;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			filter_word_q <= '0;
			filter_wr_q <= '0;
			ifmap_wr_q <= '0;
			psum_wr_q <= '0;
			filter_rd_q <= '0;
			ifmap_rd_q <= '0;
			result_q <= '0;
			out_q <= '0;
			col_q <= '0;
		end else begin
			// fresh run starts every count from zero
			if (state == ST_IDLE) begin
				filter_word_q <= '0;
				filter_wr_q <= '0;
				ifmap_wr_q <= '0;
				col_q <= '0;
			end
			if (filter_acc) begin
				filter_word_q <= filter_word_q + 4'd1;
				filter_wr_q <= filter_wr_q + FILTER_IDX_W'(q_cnt);
			end
			if (ifmap_acc)
				ifmap_wr_q <= ifmap_wr_q + IFMAP_IDX_W'(q_cnt);
			else if (slide)
				// slide keeps rs-1 words, refill lands on the top word
				ifmap_wr_q <= IFMAP_IDX_W'(win_len - 5'(q_cnt));
			if (ipsum_acc)
				psum_wr_q <= ipsum_last ? '0 : psum_wr_q + 2'd1;
			if (mac_en) begin
				filter_rd_q <= filter_rd_q + 6'd1;
				ifmap_rd_q <= conv_wrap ? '0 : ifmap_rd_q + 4'd1;
				if (conv_wrap)
					result_q <= result_q + 2'd1;
				if (conv_last) begin
					filter_rd_q <= '0;
					result_q <= '0;
				end
			end
			if (opsum_acc)
				out_q <= out_last ? '0 : out_q + 2'd1;
			if (slide)
				col_q <= col_q + 5'd1;
		end
	end

	assign ctrl_if.filter_we = filter_acc;
	assign ctrl_if.ifmap_we = ifmap_acc;
	assign ctrl_if.lanes = q_cnt;
	assign ctrl_if.filter_wr_idx = filter_wr_q;
	assign ctrl_if.ifmap_wr_idx = ifmap_wr_q;
	assign ctrl_if.psum_load = ipsum_acc;
	assign ctrl_if.psum_wr_idx = psum_wr_q;
	assign ctrl_if.mac_en = mac_en;
	assign ctrl_if.filter_rd_idx = filter_rd_q;
	assign ctrl_if.ifmap_rd_idx = ifmap_rd_q;
	assign ctrl_if.result_idx = result_q;
	assign ctrl_if.ifmap_slide = slide;
	assign ctrl_if.slide_by = q_cnt;
	assign ctrl_if.out_idx = out_q;

	a_ready_onehot: assert property (@(posedge clk) disable iff (rst)
		$onehot0({o_filter_ready, o_ifmap_ready, o_ipsum_ready}));

	// a product must never land beyond the configured channels
	a_mac_result_range: assert property (@(posedge clk) disable iff (rst)
		mac_en |-> (result_q <= cfg_q.p_m1));

endmodule

/* source/filter_spad.sv */
`timescale 1ns/100ps

module filter_spad import pe_pkg::*; (
	input logic clk,
	input logic rst,
	pe_ctrl_if.filter ctrl_if,
	input logic [DATA_W-1:0] i_word,
	output logic [LANE_W-1:0] o_weight
);

	// order is output channel, then tap, then input channel
	logic [LANE_W-1:0] mem [FILTER_LEN];
	logic [LANE_W-1:0] lane [LANES];

	always_comb begin
		for (int l = 0; l < LANES; l++)
			lane[l] = i_word[l*LANE_W +: LANE_W];
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int i = 0; i < FILTER_LEN; i++)
				mem[i] <= '0;
		end else if (ctrl_if.filter_we) begin
			// only the low q lanes carry data
			for (int l = 0; l < LANES; l++) begin
				if (l < int'(ctrl_if.lanes))
					mem[ctrl_if.filter_wr_idx + FILTER_IDX_W'(l)] <= lane[l];
			end
		end
	end

	assign o_weight = mem[ctrl_if.filter_rd_idx];

	// a full load of p*rs words ends exactly at the top
	a_filter_wr_bound: assert property (@(posedge clk) disable iff (rst)
		ctrl_if.filter_we |->
		(({1'b0, ctrl_if.filter_wr_idx} + 7'(ctrl_if.lanes)) <= 7'(FILTER_LEN)));

endmodule

/* source/ifmap_spad.sv */
`timescale 1ns/100ps

module ifmap_spad import pe_pkg::*; (
	input logic clk,
	input logic rst,
	pe_ctrl_if.ifmap ctrl_if,
	input logic [DATA_W-1:0] i_word,
	output logic [LANE_W-1:0] o_act
);

	// window of q*rs values, tap major then input channel
	logic [LANE_W-1:0] mem [IFMAP_LEN];
	logic [LANE_W-1:0] lane [LANES];
	int shift;

	// offset binary in, two's complement stored
	always_comb begin
		for (int l = 0; l < LANES; l++)
			lane[l] = i_word[l*LANE_W +: LANE_W] ^ {1'b1, {(LANE_W-1){1'b0}}};
	end

	assign shift = int'(ctrl_if.slide_by);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int i = 0; i < IFMAP_LEN; i++)
				mem[i] <= '0;
		end else if (ctrl_if.ifmap_we) begin
			for (int l = 0; l < LANES; l++) begin
				if (l < int'(ctrl_if.lanes))
					mem[ctrl_if.ifmap_wr_idx + IFMAP_IDX_W'(l)] <= lane[l];
			end
		end else if (ctrl_if.ifmap_slide) begin
			// drop the oldest tap, top entries empty out
			for (int i = 0; i < IFMAP_LEN; i++) begin
				if (i + shift < IFMAP_LEN)
					mem[i] <= mem[i + shift];
				else
					mem[i] <= '0;
			end
		end
	end

	assign o_act = mem[ctrl_if.ifmap_rd_idx];

endmodule

/* source/psum_mac.sv */
`timescale 1ns/100ps

module psum_mac import pe_pkg::*; (
	input logic clk,
	input logic rst,
	pe_ctrl_if.psum ctrl_if,
	input logic [DATA_W-1:0] i_ipsum,
	input logic [LANE_W-1:0] i_weight,
	input logic [LANE_W-1:0] i_act,
	output logic [DATA_W-1:0] o_opsum
);

	// one running sum per output channel
	logic signed [DATA_W-1:0] psum [PSUM_LEN];
	logic signed [2*LANE_W-1:0] product;
	logic signed [DATA_W-1:0] product_ext;

	// both operands are signed bytes
	assign product = $signed(i_weight) * $signed(i_act);
	assign product_ext = DATA_W'(product);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int i = 0; i < PSUM_LEN; i++)
				psum[i] <= '0;
		end else if (ctrl_if.psum_load) begin
			psum[ctrl_if.psum_wr_idx] <= $signed(i_ipsum);
		end else if (ctrl_if.mac_en) begin
			psum[ctrl_if.result_idx] <= psum[ctrl_if.result_idx] + product_ext;
		end
	end

	assign o_opsum = psum[ctrl_if.out_idx];

endmodule

/* source/pe_top.sv */
`timescale 1ns/100ps

module pe_top import pe_pkg::*; (
	input logic clk,
	input logic rst,
	input logic i_pe_en,
	input pe_cfg_t i_cfg,
	input logic [DATA_W-1:0] i_filter,
	input logic i_filter_valid,
	input logic [DATA_W-1:0] i_ifmap,
	input logic i_ifmap_valid,
	input logic [DATA_W-1:0] i_ipsum,
	input logic i_ipsum_valid,
	input logic i_opsum_ready,
	output logic o_filter_ready,
	output logic o_ifmap_ready,
	output logic o_ipsum_ready,
	output logic [DATA_W-1:0] o_opsum,
	output logic o_opsum_valid,
	output logic o_busy
);

	logic [LANE_W-1:0] weight;
	logic [LANE_W-1:0] act;

	pe_ctrl_if u_ctrl_if ();

	pe_ctrl u_ctrl (
		.clk(clk),
		.rst(rst),
		.i_pe_en(i_pe_en),
		.i_cfg(i_cfg),
		.i_filter_valid(i_filter_valid),
		.i_ifmap_valid(i_ifmap_valid),
		.i_ipsum_valid(i_ipsum_valid),
		.i_opsum_ready(i_opsum_ready),
		.o_filter_ready(o_filter_ready),
		.o_ifmap_ready(o_ifmap_ready),
		.o_ipsum_ready(o_ipsum_ready),
		.o_opsum_valid(o_opsum_valid),
		.o_busy(o_busy),
		.ctrl_if(u_ctrl_if.ctrl)
	);

	filter_spad u_filter_spad (
		.clk(clk),
		.rst(rst),
		.ctrl_if(u_ctrl_if.filter),
		.i_word(i_filter),
		.o_weight(weight)
	);

	ifmap_spad u_ifmap_spad (
		.clk(clk),
		.rst(rst),
		.ctrl_if(u_ctrl_if.ifmap),
		.i_word(i_ifmap),
		.o_act(act)
	);

	psum_mac u_psum_mac (
		.clk(clk),
		.rst(rst),
		.ctrl_if(u_ctrl_if.psum),
		.i_ipsum(i_ipsum),
		.i_weight(weight),
		.i_act(act),
		.o_opsum(o_opsum)
	);

endmodule

/* dv/pe_tb.sv */
`timescale 1ns/100ps

module pe_tb import pe_pkg::*; ();

	localparam int TIMEOUT = 500;
	localparam int N_CASES = 7;
	localparam int S_FILTER = 0;
	localparam int S_IFMAP = 1;
	localparam int S_IPSUM = 2;

	// one row of the case table
	typedef struct packed {
		pe_cfg_t cfg;
		logic bp;
		logic gaps;
	} case_row_t;

	logic clk;
	logic rst;
	logic i_pe_en;
	pe_cfg_t i_cfg;
	logic [DATA_W-1:0] i_filter;
	logic i_filter_valid;
	logic [DATA_W-1:0] i_ifmap;
	logic i_ifmap_valid;
	logic [DATA_W-1:0] i_ipsum;
	logic i_ipsum_valid;
	logic i_opsum_ready;
	logic o_filter_ready;
	logic o_ifmap_ready;
	logic o_ipsum_ready;
	logic [DATA_W-1:0] o_opsum;
	logic o_opsum_valid;
	logic o_busy;

	int value_errs = 0;
	int flag_errs = 0;
	int timeout_errs = 0;

	// reference copies of the streamed words
	logic [DATA_W-1:0] fw [16];
	logic [DATA_W-1:0] xw [40];

	// columns: {rs-1, p-1, f, q-1}, opsum back-pressure, input valid gaps
	case_row_t cases [N_CASES] = '{
		'{'{2'd0, 2'd0, 5'd0, 2'd0}, 1'b0, 1'b0},
		'{'{2'd3, 2'd3, 5'd5, 2'd3}, 1'b0, 1'b0},
		'{'{2'd3, 2'd3, 5'd3, 2'd3}, 1'b1, 1'b0},
		'{'{2'd1, 2'd2, 5'd4, 2'd1}, 1'b0, 1'b1},
		'{'{2'd2, 2'd0, 5'd6, 2'd2}, 1'b1, 1'b1},
		'{'{2'd0, 2'd1, 5'd2, 2'd3}, 1'b1, 1'b1},
		'{'{2'd3, 2'd1, 5'd9, 2'd0}, 1'b0, 1'b1}
	};

	pe_top u_dut (
		.clk(clk),
		.rst(rst),
		.i_pe_en(i_pe_en),
		.i_cfg(i_cfg),
		.i_filter(i_filter),
		.i_filter_valid(i_filter_valid),
		.i_ifmap(i_ifmap),
		.i_ifmap_valid(i_ifmap_valid),
		.i_ipsum(i_ipsum),
		.i_ipsum_valid(i_ipsum_valid),
		.i_opsum_ready(i_opsum_ready),
		.o_filter_ready(o_filter_ready),
		.o_ifmap_ready(o_ifmap_ready),
		.o_ipsum_ready(o_ipsum_ready),
		.o_opsum(o_opsum),
		.o_opsum_valid(o_opsum_valid),
		.o_busy(o_busy)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic check_opsum(input string name, input logic [DATA_W-1:0] got,
			input logic [DATA_W-1:0] exp);
		if (got !== exp) begin
			value_errs++;
			$display("** Error: %s = %h, expected %h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic check_state_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			flag_errs++;
			$display("** Error: %s = %h, expected %h at %0t", name, got, exp, $time);
		end
	endtask

	// ipsum plus sum of w * (x - 128) over taps and input channels
	function automatic logic [DATA_W-1:0] expected_opsum(input int q, input int rs,
			input int c, input int k, input logic [DATA_W-1:0] ipsum);
		int sum;
		byte w;
		int x;
		sum = int'(ipsum);
		for (int t = 0; t < rs; t++) begin
			for (int j = 0; j < q; j++) begin
				w = fw[k*rs + t][j*LANE_W +: LANE_W];
				x = int'(xw[c + t][j*LANE_W +: LANE_W]) - 128;
				sum += int'(w) * x;
			end
		end
		return DATA_W'(sum);
	endfunction

	function automatic int pick_gap(input logic gaps);
		return gaps ? int'($urandom % 3) : 0;
	endfunction

	task automatic drive_stream(input int stream, input logic [DATA_W-1:0] data,
			input logic valid);
		case (stream)
			S_FILTER: begin
				i_filter = data;
				i_filter_valid = valid;
			end
			S_IFMAP: begin
				i_ifmap = data;
				i_ifmap_valid = valid;
			end
			default: begin
				i_ipsum = data;
				i_ipsum_valid = valid;
			end
		endcase
	endtask

	function automatic logic stream_ready(input int stream);
		case (stream)
			S_FILTER: return o_filter_ready;
			S_IFMAP: return o_ifmap_ready;
			default: return o_ipsum_ready;
		endcase
	endfunction

	// offer one word, hold it until the next edge takes it
	task automatic push_word(input int stream, input logic [DATA_W-1:0] data, input int gap);
		int waited;
		logic done;
		repeat (gap) @(negedge clk);
		drive_stream(stream, data, 1'b1);
		waited = 0;
		done = 1'b0;
		while (!done && waited < TIMEOUT) begin
			if (stream_ready(stream))
				done = 1'b1;
			@(negedge clk);
			waited++;
		end
		drive_stream(stream, '0, 1'b0);
		if (!done) begin
			timeout_errs++;
			$display("input stream %0d was never accepted within %0d cycles", stream, TIMEOUT);
		end
	endtask

	task automatic pull_opsum(input logic bp, output logic [DATA_W-1:0] data);
		int waited;
		logic done;
		logic holding;
		logic [DATA_W-1:0] held;
		waited = 0;
		done = 1'b0;
		holding = 1'b0;
		held = '0;
		data = '0;
		while (!done && waited < TIMEOUT) begin
			// dropped about one cycle in three
			i_opsum_ready = bp ? logic'($urandom % 3 != 0) : 1'b1;
			if (holding) begin
				check_state_flag("o_opsum_valid", o_opsum_valid, 1'b1);
				check_opsum("o_opsum (held)", o_opsum, held);
			end
			if (o_opsum_valid && i_opsum_ready) begin
				data = o_opsum;
				done = 1'b1;
			end else if (o_opsum_valid) begin
				held = o_opsum;
				holding = 1'b1;
			end
			@(negedge clk);
			waited++;
		end
		i_opsum_ready = 1'b0;
		if (!done) begin
			timeout_errs++;
			$display("no output word arrived within %0d cycles", TIMEOUT);
		end
	endtask

	task automatic run_case(input int row);
		case_row_t cr;
		int q;
		int p;
		int rs;
		int ncol;
		logic [DATA_W-1:0] got;
		logic [DATA_W-1:0] ipsum_w [PSUM_LEN];
		cr = cases[row];
		q = int'(cr.cfg.q_m1) + 1;
		p = int'(cr.cfg.p_m1) + 1;
		rs = int'(cr.cfg.rs_m1) + 1;
		ncol = int'(cr.cfg.f) + 1;
		$display("case %0d: q=%0d p=%0d rs=%0d columns=%0d", row, q, p, rs, ncol);
		for (int i = 0; i < p*rs; i++)
			fw[i] = $urandom;
		for (int i = 0; i < ncol + rs - 1; i++)
			xw[i] = $urandom;
		i_cfg = cr.cfg;
		i_pe_en = 1'b1;
		@(negedge clk);
		i_pe_en = 1'b0;
		check_state_flag("o_filter_ready", o_filter_ready, 1'b1);
		check_state_flag("o_busy", o_busy, 1'b1);
		for (int w = 0; w < p*rs; w++)
			push_word(S_FILTER, fw[w], pick_gap(cr.gaps));
		for (int c = 0; c < ncol; c++) begin
			// first column fills the window, later ones add the newest word
			if (c == 0) begin
				for (int t = 0; t < rs; t++)
					push_word(S_IFMAP, xw[t], pick_gap(cr.gaps));
			end else begin
				push_word(S_IFMAP, xw[c + rs - 1], pick_gap(cr.gaps));
			end
			for (int k = 0; k < p; k++) begin
				ipsum_w[k] = $urandom;
				push_word(S_IPSUM, ipsum_w[k], pick_gap(cr.gaps));
			end
			for (int k = 0; k < p; k++) begin
				pull_opsum(cr.bp, got);
				check_opsum($sformatf("o_opsum col %0d ch %0d", c, k), got,
					expected_opsum(q, rs, c, k, ipsum_w[k]));
			end
			// no extra word after the p-th one
			check_state_flag("o_opsum_valid", o_opsum_valid, 1'b0);
			check_state_flag("o_busy", o_busy, logic'(c != ncol - 1));
		end
	endtask

	initial begin
		void'($urandom(32'h779a_74ed));
		rst = 1'b1;
		i_pe_en = 1'b0;
		i_cfg = '0;
		i_filter = '0;
		i_filter_valid = 1'b0;
		i_ifmap = '0;
		i_ifmap_valid = 1'b0;
		i_ipsum = '0;
		i_ipsum_valid = 1'b0;
		i_opsum_ready = 1'b0;
		repeat (4) @(negedge clk);
		rst = 1'b0;
		@(negedge clk);
		check_state_flag("o_filter_ready", o_filter_ready, 1'b0);
		check_state_flag("o_ifmap_ready", o_ifmap_ready, 1'b0);
		check_state_flag("o_ipsum_ready", o_ipsum_ready, 1'b0);
		check_state_flag("o_opsum_valid", o_opsum_valid, 1'b0);
		check_state_flag("o_busy", o_busy, 1'b0);
		for (int i = 0; i < N_CASES; i++) begin
			// a stuck handshake would only pile up more timeouts
			if (timeout_errs == 0)
				run_case(i);
			repeat (2) @(negedge clk);
		end
		$display("value errors %0d, flag errors %0d, timeouts %0d",
			value_errs, flag_errs, timeout_errs);
		if (value_errs + flag_errs + timeout_errs == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

/* sim.f */
source/pe_pkg.sv
source/pe_ctrl_if.sv
source/pe_ctrl.sv
source/filter_spad.sv
source/ifmap_spad.sv
source/psum_mac.sv
source/pe_top.sv
dv/pe_tb.sv

/* Bender.yml */
package:
  name: rs_pe

sources:
  - source/pe_pkg.sv
  - source/pe_ctrl_if.sv
  - source/pe_ctrl.sv
  - source/filter_spad.sv
  - source/ifmap_spad.sv
  - source/psum_mac.sv
  - source/pe_top.sv
  - target: simulation
    files:
      - dv/pe_tb.sv
